//--- vlog.f
rtl/uart_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_rx.sv
rtl/wb_rx_regs.sv
rtl/uart_rx_top.sv
tb/uart_rx_properties.sv
tb/uart_rx_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and pass only if the pass line was printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module uart_rx_tb -f vlog.f \
	|| { echo "build failed"; exit 1; }

out="$(./obj_dir/Vuart_rx_tb)"
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- tb/uart_rx_tb.sv
`timescale 1ns/1ns

module uart_rx_tb;

	typedef logic [$clog2(uart_pkg::NUM_CH)-1:0] ch_t;

	logic                           clk;
	logic                           rst;
	logic [uart_pkg::NUM_CH-1:0]    rxd;
	logic                           cyc;
	logic                           stb;
	logic                           we;
	logic [uart_pkg::ADR_W-1:0]     adr;
	logic [uart_pkg::DATA_BITS-1:0] dat_w;
	logic                           ack;
	logic [uart_pkg::DATA_BITS-1:0] dat_r;

	logic [15:0] lfsr_state; // random source

	// reference model, one entry per channel
	logic [uart_pkg::DATA_BITS-1:0] exp_data    [uart_pkg::NUM_CH];
	logic                           exp_valid   [uart_pkg::NUM_CH];
	logic                           exp_frame   [uart_pkg::NUM_CH];
	logic                           exp_overrun [uart_pkg::NUM_CH];

	// what each line does in the next round
	logic                           slot_used   [uart_pkg::NUM_CH];
	logic                           slot_glitch [uart_pkg::NUM_CH];
	logic                           slot_bad    [uart_pkg::NUM_CH]; // low stop bit
	logic [uart_pkg::DATA_BITS-1:0] slot_byte   [uart_pkg::NUM_CH];
	int                             slot_gap    [uart_pkg::NUM_CH]; // cycles before start

	uart_rx_top u_dut
	(
		.clk   (clk),
		.rst   (rst),
		.rxd   (rxd),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.ack   (ack),
		.dat_r (dat_r)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	////////////////////////////////////////////////////////////////////////////
	// random numbers and reporting
	////////////////////////////////////////////////////////////////////////////

	// galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	// one lfsr step per bit handed out
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			val        = {val[14:0], lfsr_state[0]};
		end
		return val;
	endfunction

	task automatic stop_on_error();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp) else
		begin
			$display("CHECK FAILED at %0t ns: %s expected 0x%02h, got 0x%02h",
				$time, name, exp, got);
			stop_on_error();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// serial lines
	////////////////////////////////////////////////////////////////////////////

	// level of one line at cycle t of a round
	function automatic logic line_level(input ch_t ch, input int t);
		int                             rel;
		int                             bit_idx;
		logic [uart_pkg::DATA_BITS-1:0] shifted;
		rel     = t - slot_gap[ch];
		bit_idx = rel / (uart_pkg::OVERSAMPLE * uart_pkg::BAUD_DIV);
		shifted = slot_byte[ch] >> (bit_idx - 1);
		if (!slot_used[ch] || rel < 0)
			return 1'b1;            // idle high
		if (slot_glitch[ch])
			return rel >= 20;       // 20 cycles low, under half a bit
		if (bit_idx == 0)
			return 1'b0;            // start bit
		if (bit_idx <= uart_pkg::DATA_BITS)
			return shifted[0];      // lsb first
		if (bit_idx == uart_pkg::DATA_BITS + 1)
			return !slot_bad[ch];   // stop bit
		return 1'b1;
	endfunction

	task automatic set_slot(input ch_t ch, input logic [7:0] b, input logic bad,
		input logic glitch, input int gap);
		slot_used[ch]   = 1'b1;
		slot_byte[ch]   = b;
		slot_bad[ch]    = bad;
		slot_glitch[ch] = glitch;
		slot_gap[ch]    = gap;
	endtask

	// character fully received, same rules as the register bank
	task automatic record_char(input ch_t ch, input logic [7:0] b, input logic bad);
		if (exp_valid[ch])
			exp_overrun[ch] = 1'b1; // old byte never read
		exp_valid[ch] = 1'b1;
		exp_frame[ch] = bad;
		exp_data[ch]  = b;
	endtask

	// all lines at once, then the model catches up
	task automatic run_round();
		ch_t c;
		// start, data, stop plus a bit of gap and a bit of settling
		for (int t = 0; t < (uart_pkg::DATA_BITS + 4) * uart_pkg::OVERSAMPLE
			* uart_pkg::BAUD_DIV; t++)
		begin
			for (int i = 0; i < uart_pkg::NUM_CH; i++)
			begin
				c      = ch_t'(i);
				rxd[c] = line_level(c, t);
			end
			@(negedge clk);
		end
		for (int i = 0; i < uart_pkg::NUM_CH; i++)
		begin
			c = ch_t'(i);
			if (slot_used[c] && !slot_glitch[c])
				record_char(c, slot_byte[c], slot_bad[c]);
			slot_used[c] = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// wishbone host
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_cycle(input logic write, input logic [uart_pkg::ADR_W-1:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		waited = 0;
		cyc    = 1'b1;
		stb    = 1'b1;
		we     = write;
		adr    = addr;
		dat_w  = wdata;
		@(negedge clk);
		while (!ack && waited < 8) // ack is due after one cycle
		begin
			@(negedge clk);
			waited++;
		end
		assert (ack) else
		begin
			$display("no Wishbone ack within 8 cycles at %0t ns", $time);
			stop_on_error();
		end
		rdata = dat_r;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		@(negedge clk); // one idle cycle between accesses
	endtask

	task automatic read_status(input ch_t ch);
		logic [7:0] got;
		logic [7:0] exp;
		exp                          = '0;
		exp[uart_pkg::ST_VALID]      = exp_valid[ch];
		exp[uart_pkg::ST_FRAME]      = exp_frame[ch];
		exp[uart_pkg::ST_OVERRUN]    = exp_overrun[ch];
		bus_cycle(1'b0, {ch, 1'(uart_pkg::REG_STATUS)}, '0, got);
		check_value($sformatf("ch%0d status", ch), exp, got);
		exp_overrun[ch] = 1'b0; // cleared by the read
	endtask

	task automatic read_data(input ch_t ch);
		logic [7:0] got;
		bus_cycle(1'b0, {ch, 1'(uart_pkg::REG_DATA)}, '0, got);
		check_value($sformatf("ch%0d data", ch), exp_data[ch], got);
		exp_valid[ch] = 1'b0;
	endtask

	// status, then byte and status again if one is waiting
	task automatic poll_channel(input ch_t ch);
		logic had_byte;
		had_byte = exp_valid[ch];
		read_status(ch);
		if (had_byte)
		begin
			read_data(ch);
			read_status(ch); // valid and overrun now clear
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		#(200 * 640 * 10 + 500_000); // 200 frames of 640 cycles, plus margin
		$display("watchdog expired at %0t ns, tests did not finish", $time);
		stop_on_error();
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		ch_t        c;
		logic [7:0] rd;
		int         chars;
		rst        = 1'b1;
		rxd        = '1; // lines idle
		cyc        = 1'b0;
		stb        = 1'b0;
		we         = 1'b0;
		adr        = '0;
		dat_w      = '0;
		lfsr_state = 16'd82;
		chars      = 0;
		for (int i = 0; i < uart_pkg::NUM_CH; i++)
		begin
			exp_data[i]    = '0;
			exp_valid[i]   = 1'b0;
			exp_frame[i]   = 1'b0;
			exp_overrun[i] = 1'b0;
			slot_used[i]   = 1'b0;
			slot_glitch[i] = 1'b0;
			slot_bad[i]    = 1'b0;
			slot_byte[i]   = '0;
			slot_gap[i]    = 0;
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// after reset, all quiet and a write changes nothing
		check_value("ack", 8'h00, {7'b0, ack});
		bus_cycle(1'b1, {ch_t'(0), 1'(uart_pkg::REG_DATA)}, 8'hA5, rd);
		for (int i = 0; i < uart_pkg::NUM_CH; i++)
			read_status(ch_t'(i));

		// good character
		c = ch_t'(rand_bits(2));
		set_slot(c, 8'(rand_bits(8)), 1'b0, 1'b0, 0);
		run_round();
		poll_channel(c);

		// bad stop bit, byte still delivered
		c = ch_t'(rand_bits(2));
		set_slot(c, 8'(rand_bits(8)), 1'b1, 1'b0, 0);
		run_round();
		poll_channel(c);

		// overrun, second byte kept
		c = ch_t'(rand_bits(2));
		set_slot(c, 8'(rand_bits(8)), 1'b0, 1'b0, 0);
		run_round();
		set_slot(c, 8'(rand_bits(8)), 1'b0, 1'b0, 0);
		run_round();
		poll_channel(c);

		// glitch must not start a character
		c = ch_t'(rand_bits(2));
		set_slot(c, '0, 1'b0, 1'b1, 0);
		run_round();
		read_status(c);

		// interleaved traffic on all lines, reads left out at random
		while (chars < 150)
		begin
			for (int i = 0; i < uart_pkg::NUM_CH; i++)
			begin
				c = ch_t'(i);
				if (rand_bits(1) == 16'd1)
				begin
					set_slot(c, 8'(rand_bits(8)), rand_bits(3) == 16'd0,
						rand_bits(3) == 16'd0, int'(rand_bits(6)));
					if (!slot_glitch[c])
						chars++;
				end
			end
			run_round();
			for (int i = 0; i < uart_pkg::NUM_CH; i++)
			begin
				if (rand_bits(1) == 16'd1)
					poll_channel(ch_t'(i));
			end
		end
		for (int i = 0; i < uart_pkg::NUM_CH; i++)
			poll_channel(ch_t'(i)); // drain what is left

		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- tb/uart_rx_properties.sv
`timescale 1ns/1ns

// handshake and pulse rules, bound into the register bank and each receiver
module uart_rx_properties
(
	input logic clk,
	input logic rst,
	input logic req,   // request or cause, answer due next cycle
	input logic ack,   // one cycle answer to req
	input logic pulse  // any signal that must stay a one cycle strobe
);

	////////////////////////////////////////////////////////////////////////////
	// request and answer
	////////////////////////////////////////////////////////////////////////////

	// answer drops again right after it was given
	a_ack_single: assert property (@(posedge clk) disable iff (rst)
		ack |-> !$past(ack))
		else $error("answer high for two cycles in a row");

	// no answer without a request the cycle before
	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		ack |-> $past(req))
		else $error("answer without a request in the previous cycle");

	////////////////////////////////////////////////////////////////////////////
	// strobes
	////////////////////////////////////////////////////////////////////////////

	a_pulse_single: assert property (@(posedge clk) disable iff (rst)
		pulse |-> !$past(pulse))
		else $error("strobe high for two cycles in a row");

endmodule

// wishbone ack against cyc and stb
// done pulses follow ticks four cycles apart so their or is a pulse too
bind wb_rx_regs uart_rx_properties u_bus_props
(
	.clk   (clk),
	.rst   (rst),
	.req   (cyc && stb),
	.ack   (ack),
	.pulse (|done_vec)
);

// rx_done only on the cycle after a tick
// tick itself one cycle wide
bind uart_rx uart_rx_properties u_rx_props
(
	.clk   (clk),
	.rst   (rst),
	.req   (tick),
	.ack   (rx_done),
	.pulse (tick)
);

//--- rtl/uart_rx_top.sv
`timescale 1ns/1ns

// four channel polled uart receiver
module uart_rx_top
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic [uart_pkg::NUM_CH-1:0]    rxd,   // one serial line per channel

	// wishbone classic slave
	input  logic                           cyc,
	input  logic                           stb,
	input  logic                           we,
	input  logic [uart_pkg::ADR_W-1:0]     adr,
	input  logic [uart_pkg::DATA_BITS-1:0] dat_w,
	output logic                           ack,
	output logic [uart_pkg::DATA_BITS-1:0] dat_r
);

	logic                                                  tick;     // shared 16x strobe
	logic [uart_pkg::NUM_CH-1:0]                           done_vec;
	logic [uart_pkg::NUM_CH-1:0][uart_pkg::DATA_BITS-1:0] data_vec;
	logic [uart_pkg::NUM_CH-1:0]                           ferr_vec;

	baud_tick_gen u_tick
	(
		.clk  (clk),
		.rst  (rst),
		.tick (tick)
	);

	// one receiver per line, all on the same tick phase
	for (genvar ch = 0; ch < uart_pkg::NUM_CH; ch++)
	begin : g_ch
		uart_rx u_rx
		(
			.clk       (clk),
			.rst       (rst),
			.tick      (tick),
			.rxd       (rxd[ch]),
			.rx_done   (done_vec[ch]),
			.rx_data   (data_vec[ch]),
			.frame_err (ferr_vec[ch])
		);
	end

	wb_rx_regs u_regs
	(
		.clk      (clk),
		.rst      (rst),
		.done_vec (done_vec),
		.data_vec (data_vec),
		.ferr_vec (ferr_vec),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.dat_w    (dat_w),
		.ack      (ack),
		.dat_r    (dat_r)
	);

endmodule

//--- rtl/wb_rx_regs.sv
`timescale 1ns/1ns

// wishbone classic slave, one holding register and flag set per channel
module wb_rx_regs
(
	input  logic                                                  clk,
	input  logic                                                  rst,
	input  logic [uart_pkg::NUM_CH-1:0]                           done_vec,
	input  logic [uart_pkg::NUM_CH-1:0][uart_pkg::DATA_BITS-1:0] data_vec,
	input  logic [uart_pkg::NUM_CH-1:0]                           ferr_vec,
	input  logic                                                  cyc,
	input  logic                                                  stb,
	input  logic                                                  we,
	input  logic [uart_pkg::ADR_W-1:0]                            adr,
	input  logic [uart_pkg::DATA_BITS-1:0]                        dat_w, // read only map
	output logic                                                  ack,
	output logic [uart_pkg::DATA_BITS-1:0]                        dat_r
);

	// per channel state
	logic [uart_pkg::NUM_CH-1:0][uart_pkg::DATA_BITS-1:0] data_q; // held byte
	logic [uart_pkg::NUM_CH-1:0] valid_q;   // byte waiting
	logic [uart_pkg::NUM_CH-1:0] frame_q;   // stop bit of last byte was low
	logic [uart_pkg::NUM_CH-1:0] overrun_q; // byte lost

	// decode
	logic [uart_pkg::ADR_W-2:0]  ch_sel;    // upper address bits
	logic                        reg_sel;   // data or status
	logic                        req;       // new cycle, ack goes out next edge
	logic                        rd_req;
	logic [uart_pkg::NUM_CH-1:0] clr_valid;
	logic [uart_pkg::NUM_CH-1:0] clr_overrun;

	// read mux
	logic [uart_pkg::DATA_BITS-1:0] status_word;
	logic [uart_pkg::DATA_BITS-1:0] rd_word;

	assign ch_sel  = adr[uart_pkg::ADR_W-1:1];
	assign reg_sel = adr[0];
	assign req     = cyc & stb & ~ack; // ~ack keeps ack to a single cycle
	assign rd_req  = req & ~we;        // writes just get acked

	////////////////////////////////////////////////////////////////////////////
	// read side effects
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < uart_pkg::NUM_CH; i++)
		begin
			clr_valid[i]   = rd_req && (ch_sel == (uart_pkg::ADR_W-1)'(i))
				&& (reg_sel == 1'(uart_pkg::REG_DATA));
			clr_overrun[i] = rd_req && (ch_sel == (uart_pkg::ADR_W-1)'(i))
				&& (reg_sel == 1'(uart_pkg::REG_STATUS));
		end
	end

	// flags, a new byte beats a clearing read on the same edge
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_q   <= '0;
			frame_q   <= '0;
			overrun_q <= '0;
		end
		else
		begin
			for (int i = 0; i < uart_pkg::NUM_CH; i++)
			begin
				if (clr_valid[i])
					valid_q[i] <= 1'b0;
				if (clr_overrun[i])
					overrun_q[i] <= 1'b0;
				if (done_vec[i])
				begin
					valid_q[i] <= 1'b1;
					frame_q[i] <= ferr_vec[i]; // follows every byte
					// old byte still unread and not being read right now
					if (valid_q[i] && !clr_valid[i])
						overrun_q[i] <= 1'b1;
				end
			end
		end
	end

	// holding registers, new byte always replaces old
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < uart_pkg::NUM_CH; i++)
		begin
			if (done_vec[i])
				data_q[i] <= data_vec[i];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus response
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		status_word = '0;
		status_word[uart_pkg::ST_VALID]   = valid_q[ch_sel];
		status_word[uart_pkg::ST_FRAME]   = frame_q[ch_sel];
		status_word[uart_pkg::ST_OVERRUN] = overrun_q[ch_sel];
		if (reg_sel == 1'(uart_pkg::REG_STATUS))
			rd_word = status_word;
		else
			rd_word = data_q[ch_sel];
	end

	// ack one cycle after cyc & stb, then low again
	always_ff @(posedge clk)
	begin
		if (rst)
			ack <= 1'b0;
		else
			ack <= req;
	end

	// read data captured with pre-clear flag values
	always_ff @(posedge clk)
	begin
		if (rd_req)
			dat_r <= rd_word;
	end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ns

// one receive channel, 8N1, 16x oversampled off the shared tick
module uart_rx
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           tick,      // 16x strobe
	input  logic                           rxd,       // async serial line
	output logic                           rx_done,   // one cycle per char
	output logic [uart_pkg::DATA_BITS-1:0] rx_data,   // valid with rx_done
	output logic                           frame_err  // valid with rx_done
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} state_t;

	state_t                      state;
	logic                        rxd_meta;  // first sync stage
	logic                        rxd_sync;  // line as seen by the fsm
	logic [uart_pkg::TICK_W-1:0] tick_cnt;  // ticks inside current bit
	logic [uart_pkg::BIT_W-1:0]  bit_cnt;   // data bits taken so far
	logic                        mid_start; // middle of start bit
	logic                        bit_end;   // one full bit period counted

	assign mid_start = (tick_cnt == uart_pkg::TICK_W'(uart_pkg::OVERSAMPLE / 2 - 1));
	assign bit_end   = (tick_cnt == uart_pkg::TICK_W'(uart_pkg::OVERSAMPLE - 1));

	////////////////////////////////////////////////////////////////////////////
	// input synchronizer
	////////////////////////////////////////////////////////////////////////////

	// two flops, line idles high so reset to 1
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// start / data / stop fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= S_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			rx_done  <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0; // pulse, cleared every clk not every tick
			if (tick)
			begin
				case (state)
				S_IDLE:
					if (!rxd_sync) // falling edge, maybe a start bit
					begin
						state    <= S_START;
						tick_cnt <= '0;
					end
				S_START:
					if (mid_start)
					begin
						tick_cnt <= '0;
						bit_cnt  <= '0;
						// line back high mid start bit means a glitch
						state    <= rxd_sync ? S_IDLE : S_DATA;
					end
					else
						tick_cnt <= tick_cnt + 1'b1;
				S_DATA:
					if (bit_end) // middle of next data bit
					begin
						tick_cnt <= '0;
						if (bit_cnt == uart_pkg::BIT_W'(uart_pkg::DATA_BITS - 1))
							state <= S_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
					else
						tick_cnt <= tick_cnt + 1'b1;
				S_STOP:
					if (bit_end) // middle of stop bit
					begin
						tick_cnt <= '0;
						state    <= S_IDLE;
						rx_done  <= 1'b1; // fires good frame or bad
					end
					else
						tick_cnt <= tick_cnt + 1'b1;
				default:
					state <= S_IDLE;
				endcase
			end
		end
	end

	// payload, lsb first shift and stop bit judgement
	always_ff @(posedge clk)
	begin
		if (tick && state == S_DATA && bit_end)
			rx_data <= {rxd_sync, rx_data[uart_pkg::DATA_BITS-1:1]};
		if (tick && state == S_STOP && bit_end)
			frame_err <= ~rxd_sync; // stop must be high
	end

endmodule

//--- rtl/baud_tick_gen.sv
`timescale 1ns/1ns

// one shared oversampling strobe for all receive channels
module baud_tick_gen
(
	input  logic clk,
	input  logic rst,
	output logic tick
);

	logic [$clog2(uart_pkg::BAUD_DIV)-1:0] div_cnt; // down counter

	// counter walks down to zero, tick is registered off the zero state
	// so first tick lands BAUD_DIV cycles after reset drops
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			div_cnt <= ($clog2(uart_pkg::BAUD_DIV))'(uart_pkg::BAUD_DIV - 1);
			tick    <= 1'b0;
		end
		else if (div_cnt == '0)
		begin
			div_cnt <= ($clog2(uart_pkg::BAUD_DIV))'(uart_pkg::BAUD_DIV - 1); // reload
			tick    <= 1'b1; // one cycle wide
		end
		else
		begin
			div_cnt <= div_cnt - 1'b1;
			tick    <= 1'b0;
		end
	end

endmodule

//--- rtl/uart_pkg.sv
package uart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// channel and character sizing
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_CH     = 4;  // receive channels
	localparam int DATA_BITS  = 8;  // bits per char, also wishbone data width

	// oversampling, one bit is OVERSAMPLE ticks
	localparam int OVERSAMPLE = 16;
	localparam int TICK_W     = 4;  // tick counter width in each receiver
	localparam int BIT_W      = 3;  // data bit counter width

	// clk cycles per tick, 64 cycles per bit
	localparam int BAUD_DIV   = 4;

	////////////////////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////////////////////

	localparam int ADR_W      = 3;  // word address, channel in upper bits

	// register pair per channel at adr = ch*2
	localparam int REG_DATA   = 0;  // read returns byte, clears valid
	localparam int REG_STATUS = 1;  // read returns flags, clears overrun

	// status bit positions
	localparam int ST_VALID   = 0;  // byte waiting
	localparam int ST_FRAME   = 1;  // last byte had a bad stop bit
	localparam int ST_OVERRUN = 2;  // byte replaced before it was read

endpackage
